// ==== source/sched_pkg.sv ====
// shared definitions for the packet scheduler
//   word layout of one buffer word (sop, eop, payload)
//   packet stamp type
//   stamp position and minimum packet length
package sched_pkg;

    // --------------------------------------------------
    // word layout
    // --------------------------------------------------

    // full buffer word width
    localparam int WORD_WIDTH = 18;

    // flag positions
    localparam int SOP_BIT = 17;
    localparam int EOP_BIT = 16;

    // payload occupies the low bits
    localparam int PAYLOAD_WIDTH = 16;

    // one word as it moves from channel to output port
    typedef logic [WORD_WIDTH-1:0] word_t;

    // --------------------------------------------------
    // packet stamp
    // --------------------------------------------------

    // running packet stamp, same width as the payload
    typedef logic [PAYLOAD_WIDTH-1:0] stamp_t;

    // zero-based word index that carries the stamp
    localparam int STAMP_WORD_INDEX = 2;

    // shortest legal packet, so the stamp word always exists
    localparam int MIN_PKT_WORDS = 3;

endpackage

// ==== source/buf_reader.sv ====
// read control for one output port
//   wrapping read pointer
//   packet-ready flag, set on packet_done, cleared after eop read
//   read strobe and delayed valid
`timescale 1ns/1ps

module buf_reader #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                  clk_sys,
    input  logic                  rst_sys,
    input  logic                  packet_done,
    input  logic [ADDR_WIDTH-1:0] eop_addr,
    input  logic                  rd_req,
    output logic [ADDR_WIDTH-1:0] rd_addr,
    output logic                  rd_dval,
    output logic                  pkt_ready
);

    logic                  rd_en;
    logic [ADDR_WIDTH-1:0] rd_ptr;

    // read only while a packet is pending
    assign rd_en   = pkt_ready & rd_req;
    assign rd_addr = rd_ptr;

    always_ff @(posedge clk_sys or negedge rst_sys) begin
        if (!rst_sys) begin
            rd_ptr  <= '0;
            rd_dval <= 1'b0;
        end else begin
            // data leaves the memory one cycle after the read
            rd_dval <= rd_en;
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // eop found by address, never reads past it
    always_ff @(posedge clk_sys or negedge rst_sys) begin
        if (!rst_sys) begin
            pkt_ready <= 1'b0;
        end else if (packet_done) begin
            pkt_ready <= 1'b1;
        end else if (rd_en && (rd_ptr == eop_addr)) begin
            pkt_ready <= 1'b0;
        end
    end

endmodule

// ==== source/pkt_buffer.sv ====
// single-packet buffer with two readers
//   inferred memory, one write port, two registered read ports
//   wrapping write pointer and eop address
//   packet_done to the readers, buf_busy to the scheduler
`timescale 1ns/1ps

module pkt_buffer
    import sched_pkg::*;
#(
    parameter int ADDR_WIDTH = 10
) (
    input  logic  clk_sys,
    input  logic  rst_sys,
    input  logic  wr_en,
    input  word_t wr_word,
    output logic  buf_busy,
    input  logic  rd_req_0,
    input  logic  rd_req_1,
    output logic  rd_dval_0,
    output logic  rd_dval_1,
    output word_t rd_data_0,
    output word_t rd_data_1
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    word_t                 mem [DEPTH];
    logic [ADDR_WIDTH-1:0] wr_ptr;
    logic [ADDR_WIDTH-1:0] eop_addr;
    logic [ADDR_WIDTH-1:0] rd_addr_0;
    logic [ADDR_WIDTH-1:0] rd_addr_1;
    logic                  packet_done;
    logic                  pkt_ready_0;
    logic                  pkt_ready_1;

    // --------------------------------------------------
    // write side
    // --------------------------------------------------

    // pointer wraps at the end of the address space
    always_ff @(posedge clk_sys or negedge rst_sys) begin
        if (!rst_sys) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // memory write and eop address capture
    always_ff @(posedge clk_sys) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_word;
        end
        if (packet_done) begin
            eop_addr <= wr_ptr;
        end
    end

    // whole packet now in memory
    assign packet_done = wr_en & wr_word[EOP_BIT];

    // --------------------------------------------------
    // read side
    // --------------------------------------------------

    // registered read ports, one per output
    always_ff @(posedge clk_sys) begin
        rd_data_0 <= mem[rd_addr_0];
        rd_data_1 <= mem[rd_addr_1];
    end

    buf_reader #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) i_reader_0 (
        .clk_sys     (clk_sys),
        .rst_sys     (rst_sys),
        .packet_done (packet_done),
        .eop_addr    (eop_addr),
        .rd_req      (rd_req_0),
        .rd_addr     (rd_addr_0),
        .rd_dval     (rd_dval_0),
        .pkt_ready   (pkt_ready_0)
    );

    buf_reader #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) i_reader_1 (
        .clk_sys     (clk_sys),
        .rst_sys     (rst_sys),
        .packet_done (packet_done),
        .eop_addr    (eop_addr),
        .rd_req      (rd_req_1),
        .rd_addr     (rd_addr_1),
        .rd_dval     (rd_dval_1),
        .pkt_ready   (pkt_ready_1)
    );

    // held until both ports have read the eop
    assign buf_busy = pkt_ready_0 | pkt_ready_1;

endmodule

// ==== source/pkt_stamper.sv ====
// packet stamper write stage
//   word index counter from sop
//   running stamp counter, first packet gets 1
//   registered write port toward the buffer
`timescale 1ns/1ps

module pkt_stamper
    import sched_pkg::*;
(
    input  logic  clk_sys,
    input  logic  rst_sys,
    input  logic  in_valid,
    input  word_t in_word,
    output logic  wr_en,
    output word_t wr_word
);

    // counter saturates just past the stamp word
    localparam int CNT_WIDTH = $clog2(STAMP_WORD_INDEX + 2);
    localparam int CNT_MAX   = STAMP_WORD_INDEX + 1;

    logic [CNT_WIDTH-1:0] word_cnt;
    logic [CNT_WIDTH-1:0] cur_idx;
    logic                 stamp_hit;
    stamp_t               stamp_cnt;
    word_t                stamped_word;

    // index of the current word, sop restarts at zero
    assign cur_idx   = in_word[SOP_BIT] ? '0 : word_cnt;
    assign stamp_hit = (cur_idx == CNT_WIDTH'(STAMP_WORD_INDEX));

    always_ff @(posedge clk_sys or negedge rst_sys) begin
        if (!rst_sys) begin
            word_cnt <= '0;
        end else if (in_valid) begin
            if (cur_idx != CNT_WIDTH'(CNT_MAX)) begin
                word_cnt <= cur_idx + 1'b1;
            end else begin
                word_cnt <= cur_idx;
            end
        end
    end

    // bumped on sop, so the stamp word of packet k sees k
    always_ff @(posedge clk_sys or negedge rst_sys) begin
        if (!rst_sys) begin
            stamp_cnt <= '0;
        end else if (in_valid && in_word[SOP_BIT]) begin
            stamp_cnt <= stamp_cnt + 1'b1;
        end
    end

    // payload replaced, flags kept
    // a minimal packet has its eop on the stamp word
    always_comb begin
        stamped_word                      = in_word;
        stamped_word[PAYLOAD_WIDTH-1:0] = stamp_cnt;
    end

    // --------------------------------------------------
    // write register
    // --------------------------------------------------
    always_ff @(posedge clk_sys or negedge rst_sys) begin
        if (!rst_sys) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= in_valid;
        end
    end

    always_ff @(posedge clk_sys) begin
        wr_word <= stamp_hit ? stamped_word : in_word;
    end

endmodule

// ==== source/chn_scheduler.sv ====
// round-robin channel scheduler
//   grant register and last-served index
//   FSM: pick, read, await data, settle, drain
//   one channel read outstanding at a time
//   registered word output to the stamper
`timescale 1ns/1ps

module chn_scheduler
    import sched_pkg::*;
#(
    parameter int CHN_NUM = 5
) (
    input  logic               clk_sys,
    input  logic               rst_sys,
    input  logic [CHN_NUM-1:0] chn_empty,
    input  logic [CHN_NUM-1:0] chn_dval,
    input  word_t              chn_data,
    output logic [CHN_NUM-1:0] chn_rden,
    input  logic               buf_busy,
    output logic               in_valid,
    output word_t              in_word
);

    localparam int IDX_WIDTH = (CHN_NUM > 1) ? $clog2(CHN_NUM) : 1;

    typedef enum logic [2:0] {
        ST_PICK,
        ST_READ,
        ST_AWAIT,
        ST_SETTLE,
        ST_DRAIN
    } state_t;

    state_t               state;
    logic [IDX_WIDTH-1:0] grant_idx;
    logic [IDX_WIDTH-1:0] last_idx;
    logic [IDX_WIDTH-1:0] next_idx;
    logic                 next_found;
    logic                 grant_dval;
    logic                 grant_eop;

    // --------------------------------------------------
    // round-robin search
    // --------------------------------------------------

    // first non-empty channel after the last served one,
    // the last served channel itself is tried last
    always_comb begin
        int cand;
        next_found = 1'b0;
        next_idx   = last_idx;
        for (int k = 1; k <= CHN_NUM; k++) begin
            cand = (int'(last_idx) + k) % CHN_NUM;
            if (!next_found && !chn_empty[cand]) begin
                next_found = 1'b1;
                next_idx   = IDX_WIDTH'(cand);
            end
        end
    end

    // --------------------------------------------------
    // channel read strobe and returned word
    // --------------------------------------------------

    // single pop, only in the read state
    always_comb begin
        chn_rden = '0;
        if (state == ST_READ) begin
            chn_rden[grant_idx] = 1'b1;
        end
    end

    // word of the granted channel came back
    assign grant_dval = chn_dval[grant_idx];
    assign grant_eop  = grant_dval & chn_data[EOP_BIT];

    // --------------------------------------------------
    // FSM
    // --------------------------------------------------
    always_ff @(posedge clk_sys or negedge rst_sys) begin
        if (!rst_sys) begin
            state     <= ST_PICK;
            grant_idx <= '0;
            // channel 0 is searched first after reset
            last_idx  <= IDX_WIDTH'(CHN_NUM - 1);
        end else begin
            case (state)
                ST_PICK: begin
                    // buffer must be fully drained by both ports
                    if (!buf_busy && next_found) begin
                        grant_idx <= next_idx;
                        state     <= ST_READ;
                    end
                end
                ST_READ: begin
                    state <= ST_AWAIT;
                end
                ST_AWAIT: begin
                    if (grant_eop) begin
                        last_idx <= grant_idx;
                        state    <= ST_SETTLE;
                    end else if (grant_dval) begin
                        state <= ST_READ;
                    end
                end
                ST_SETTLE: begin
                    // eop still on its way into the buffer
                    state <= ST_DRAIN;
                end
                ST_DRAIN: begin
                    if (!buf_busy) begin
                        state <= ST_PICK;
                    end
                end
                default: begin
                    state <= ST_PICK;
                end
            endcase
        end
    end

    // --------------------------------------------------
    // output register toward the stamper
    // --------------------------------------------------
    always_ff @(posedge clk_sys or negedge rst_sys) begin
        if (!rst_sys) begin
            in_valid <= 1'b0;
        end else begin
            in_valid <= |chn_dval;
        end
    end

    // shared data bus, qualified by in_valid
    always_ff @(posedge clk_sys) begin
        in_word <= chn_data;
    end

endmodule

// ==== source/sched_top.sv ====
// top level of the packet scheduler
//   channel scheduler -> stamper -> packet buffer
//   buffer drives both output ports
`timescale 1ns/1ps

module sched_top
    import sched_pkg::*;
#(
    parameter int CHN_NUM    = 5,
    parameter int ADDR_WIDTH = 10
) (
    input  logic               clk_sys,
    input  logic               rst_sys,
    input  logic [CHN_NUM-1:0] chn_empty,
    input  logic [CHN_NUM-1:0] chn_dval,
    input  word_t              chn_data,
    output logic [CHN_NUM-1:0] chn_rden,
    input  logic               rd_req_0,
    input  logic               rd_req_1,
    output logic               rd_dval_0,
    output logic               rd_dval_1,
    output word_t              rd_data_0,
    output word_t              rd_data_1
);

    // scheduler to stamper
    logic  in_valid;
    word_t in_word;

    // stamper to buffer
    logic  wr_en;
    word_t wr_word;

    // buffer back to scheduler
    logic  buf_busy;

    chn_scheduler #(
        .CHN_NUM (CHN_NUM)
    ) i_chn_scheduler (
        .clk_sys   (clk_sys),
        .rst_sys   (rst_sys),
        .chn_empty (chn_empty),
        .chn_dval  (chn_dval),
        .chn_data  (chn_data),
        .chn_rden  (chn_rden),
        .buf_busy  (buf_busy),
        .in_valid  (in_valid),
        .in_word   (in_word)
    );

    pkt_stamper i_pkt_stamper (
        .clk_sys  (clk_sys),
        .rst_sys  (rst_sys),
        .in_valid (in_valid),
        .in_word  (in_word),
        .wr_en    (wr_en),
        .wr_word  (wr_word)
    );

    pkt_buffer #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) i_pkt_buffer (
        .clk_sys   (clk_sys),
        .rst_sys   (rst_sys),
        .wr_en     (wr_en),
        .wr_word   (wr_word),
        .buf_busy  (buf_busy),
        .rd_req_0  (rd_req_0),
        .rd_req_1  (rd_req_1),
        .rd_dval_0 (rd_dval_0),
        .rd_dval_1 (rd_dval_1),
        .rd_data_0 (rd_data_0),
        .rd_data_1 (rd_data_1)
    );

endmodule

// ==== sim/tb_sched.sv ====
// testbench for the packet scheduler
//   channel models fed from per-channel word queues
//   random output port requests, port 1 hold for back-pressure
//   round-robin reference model with packet stamps
//   concurrent assertions and a watchdog
`timescale 1ns/1ps

module tb_sched
    import sched_pkg::*;
();

    localparam int          CHN_NUM      = 5;
    localparam int          ADDR_WIDTH   = 10;
    localparam int          DEPTH        = 2 ** ADDR_WIDTH;
    localparam int          RESET_CYCLES = 10;
    localparam int          HOLD_CYCLES  = 300;
    localparam logic [31:0] LFSR_SEED    = 32'h92c9;
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;

    logic               clk_sys;
    logic               rst_sys;
    logic [CHN_NUM-1:0] chn_empty;
    logic [CHN_NUM-1:0] chn_dval;
    word_t              chn_data;
    logic [CHN_NUM-1:0] chn_rden;
    logic               rd_req_0;
    logic               rd_req_1;
    logic               rd_dval_0;
    logic               rd_dval_1;
    word_t              rd_data_0;
    word_t              rd_data_1;

    // channel contents as seen by the DUT, and a copy for the model
    word_t       chan_q  [CHN_NUM][$];
    word_t       model_q [CHN_NUM][$];
    word_t       exp_stream[$];
    logic [31:0] lfsr        = LFSR_SEED;
    int          model_last  = CHN_NUM - 1;
    int          stamp_num   = 0;
    int          pkt_total   = 0;
    int          total_words = 0;
    logic        any_loaded  = 1'b0;
    logic        hold_1      = 1'b0;

    // per port position in the expected stream
    int    pos_0       = 0;
    int    pos_1       = 0;
    logic  exp_avail_0 = 1'b0;
    logic  exp_avail_1 = 1'b0;
    word_t exp_word_0  = '0;
    word_t exp_word_1  = '0;

    // eop counts, into the DUT and out of each port
    int eop_in    = 0;
    int eop_out_0 = 0;
    int eop_out_1 = 0;

    sched_top #(
        .CHN_NUM    (CHN_NUM),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) i_sched_top (
        .clk_sys   (clk_sys),
        .rst_sys   (rst_sys),
        .chn_empty (chn_empty),
        .chn_dval  (chn_dval),
        .chn_data  (chn_data),
        .chn_rden  (chn_rden),
        .rd_req_0  (rd_req_0),
        .rd_req_1  (rd_req_1),
        .rd_dval_0 (rd_dval_0),
        .rd_dval_1 (rd_dval_1),
        .rd_data_0 (rd_data_0),
        .rd_data_1 (rd_data_1)
    );

    initial begin
        clk_sys = 1'b0;
        forever #20 clk_sys = ~clk_sys;
    end

    // --------------------------------------------------
    // random numbers and error reporting
    // --------------------------------------------------

    // galois LFSR, one step per bit
    function automatic logic next_bit();
        logic bit_out;
        bit_out = lfsr[0];
        lfsr    = lfsr >> 1;
        if (bit_out) begin
            lfsr = lfsr ^ LFSR_TAPS;
        end
        return bit_out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], next_bit()};
        end
        return val;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic report_violation(input string what);
        $display("error: %s", what);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------

    // round-robin over what is queued, stamp k into word 2 of packet k
    task automatic build_expected();
        int    ch;
        int    cand;
        int    idx;
        logic  found;
        word_t w;
        found = 1'b1;
        while (found) begin
            found = 1'b0;
            ch    = 0;
            for (int k = 1; k <= CHN_NUM; k++) begin
                cand = (model_last + k) % CHN_NUM;
                if (!found && model_q[cand].size() > 0) begin
                    found = 1'b1;
                    ch    = cand;
                end
            end
            if (found) begin
                stamp_num++;
                idx = 0;
                do begin
                    w = model_q[ch].pop_front();
                    if (idx == STAMP_WORD_INDEX) begin
                        w[PAYLOAD_WIDTH-1:0] = stamp_t'(stamp_num);
                    end
                    exp_stream.push_back(w);
                    idx++;
                end while (!w[EOP_BIT]);
                model_last = ch;
            end
        end
    endtask

    // n random packets of 3 to 16 words on random channels
    task automatic load_packets(input int n);
        int    ch;
        int    len;
        word_t w;
        for (int p = 0; p < n; p++) begin
            ch  = int'(rand_bits(3)) % CHN_NUM;
            len = MIN_PKT_WORDS + int'(rand_bits(4)) % 14;
            for (int i = 0; i < len; i++) begin
                w                    = '0;
                w[SOP_BIT]           = (i == 0);
                w[EOP_BIT]           = (i == len - 1);
                w[PAYLOAD_WIDTH-1:0] = rand_bits(PAYLOAD_WIDTH);
                chan_q[ch].push_back(w);
                model_q[ch].push_back(w);
            end
            pkt_total++;
            total_words += len;
        end
        build_expected();
        any_loaded = 1'b1;
    endtask

    // both ports have delivered the whole expected stream
    task automatic wait_drained();
        while (pos_0 != exp_stream.size() || pos_1 != exp_stream.size()) begin
            @(negedge clk_sys);
        end
    endtask

    // --------------------------------------------------
    // channel model and port requests
    // --------------------------------------------------

    // pop in cycle t, word with dval in t+1
    always @(posedge clk_sys) begin : chan_model
        logic [CHN_NUM-1:0] dval_nxt;
        logic [CHN_NUM-1:0] empty_nxt;
        word_t              data_nxt;
        dval_nxt = '0;
        data_nxt = chn_data;
        for (int c = 0; c < CHN_NUM; c++) begin
            if (chn_rden[c] && chan_q[c].size() > 0) begin
                data_nxt    = chan_q[c].pop_front();
                dval_nxt[c] = 1'b1;
            end
            empty_nxt[c] = (chan_q[c].size() == 0);
        end
        chn_dval  <= dval_nxt;
        chn_data  <= data_nxt;
        chn_empty <= empty_nxt;
    end

    always @(posedge clk_sys) begin
        rd_req_0 <= next_bit();
        rd_req_1 <= hold_1 ? 1'b0 : next_bit();
    end

    // expected word for each port's next valid
    always @(posedge clk_sys) begin : port_track
        int nxt_0;
        int nxt_1;
        nxt_0       = pos_0 + (rd_dval_0 ? 1 : 0);
        nxt_1       = pos_1 + (rd_dval_1 ? 1 : 0);
        pos_0       <= nxt_0;
        pos_1       <= nxt_1;
        exp_avail_0 <= (nxt_0 < exp_stream.size());
        exp_avail_1 <= (nxt_1 < exp_stream.size());
        exp_word_0  <= (nxt_0 < exp_stream.size()) ? exp_stream[nxt_0] : '0;
        exp_word_1  <= (nxt_1 < exp_stream.size()) ? exp_stream[nxt_1] : '0;
        if (rd_dval_0 && rd_data_0[EOP_BIT]) begin
            eop_out_0 <= eop_out_0 + 1;
        end
        if (rd_dval_1 && rd_data_1[EOP_BIT]) begin
            eop_out_1 <= eop_out_1 + 1;
        end
        if (|chn_dval && chn_data[EOP_BIT]) begin
            eop_in <= eop_in + 1;
        end
    end

    // --------------------------------------------------
    // assertions
    // --------------------------------------------------

    // quiet until the first packet is queued
    assert property (@(posedge clk_sys) disable iff (!rst_sys)
        !any_loaded |-> (chn_rden == '0 && !rd_dval_0 && !rd_dval_1))
        else report_mismatch("idle_outputs", '0, $sampled({chn_rden, rd_dval_0, rd_dval_1}));

    assert property (@(posedge clk_sys) disable iff (!rst_sys) $onehot0(chn_rden))
        else report_violation("more than one chn_rden bit high in one cycle");

    assert property (@(posedge clk_sys) disable iff (!rst_sys) (chn_rden & chn_empty) == '0)
        else report_mismatch("rden_empty", '0, $sampled(chn_rden & chn_empty));

    // two cycles between pops
    assert property (@(posedge clk_sys) disable iff (!rst_sys)
        $past(chn_rden) != '0 |-> chn_rden == '0)
        else report_mismatch("rden_spacing", '0, $sampled(chn_rden));

    assert property (@(posedge clk_sys) disable iff (!rst_sys) rd_dval_0 |-> exp_avail_0)
        else report_violation("port 0 delivered a word beyond the expected stream");

    assert property (@(posedge clk_sys) disable iff (!rst_sys) rd_dval_1 |-> exp_avail_1)
        else report_violation("port 1 delivered a word beyond the expected stream");

    assert property (@(posedge clk_sys) disable iff (!rst_sys)
        rd_dval_0 |-> rd_data_0 == exp_word_0)
        else report_mismatch("port0_data", $sampled(exp_word_0), $sampled(rd_data_0));

    assert property (@(posedge clk_sys) disable iff (!rst_sys)
        rd_dval_1 |-> rd_data_1 == exp_word_1)
        else report_mismatch("port1_data", $sampled(exp_word_1), $sampled(rd_data_1));

    // a valid only follows a request
    assert property (@(posedge clk_sys) disable iff (!rst_sys) rd_dval_0 |-> $past(rd_req_0))
        else report_violation("rd_dval_0 high without a read request");

    assert property (@(posedge clk_sys) disable iff (!rst_sys) rd_dval_1 |-> $past(rd_req_1))
        else report_violation("rd_dval_1 high without a read request");

    // no channel read while either port still owes an eop
    assert property (@(posedge clk_sys) disable iff (!rst_sys)
        (eop_in != eop_out_0 || eop_in != eop_out_1) |-> chn_rden == '0)
        else report_mismatch("backpressure_rden", '0, $sampled(chn_rden));

    // --------------------------------------------------
    // phases
    // --------------------------------------------------
    initial begin : stimulus
        int base;
        rst_sys   <= 1'b0;
        chn_empty <= '1;
        chn_dval  <= '0;
        chn_data  <= '0;
        rd_req_0  <= 1'b0;
        rd_req_1  <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_sys);
        rst_sys <= 1'b1;
        // phase 1, nothing queued
        repeat (20) @(negedge clk_sys);
        // phases 2 and 3, plain round-robin runs
        load_packets(30);
        wait_drained();
        @(negedge clk_sys);
        load_packets(40);
        wait_drained();
        // phase 4, keep going until the write pointer has wrapped
        while (total_words <= DEPTH + 64) begin
            @(negedge clk_sys);
            load_packets(10);
            wait_drained();
        end
        // phase 5, port 1 stalls with a packet pending
        @(negedge clk_sys);
        hold_1 = 1'b1;
        base   = eop_out_0;
        load_packets(3);
        while (eop_out_0 == base) begin
            @(negedge clk_sys);
        end
        repeat (HOLD_CYCLES) @(negedge clk_sys);
        hold_1 = 1'b0;
        wait_drained();
        repeat (10) @(negedge clk_sys);
        $display("ALL CHECKS PASSED");
        $finish;
    end

    // limit grows with every queued packet
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles <= RESET_CYCLES + HOLD_CYCLES + 100 + 200 * pkt_total) begin
            @(posedge clk_sys);
            cycles++;
        end
        $display("error: timeout, the queued packets were not delivered in time");
        $display("CHECKS FAILED");
        $fatal(1);
    end

endmodule

// ==== list.f ====
source/sched_pkg.sv
source/buf_reader.sv
source/pkt_buffer.sv
source/pkt_stamper.sv
source/chn_scheduler.sv
source/sched_top.sv
sim/tb_sched.sv
